/* Makefile */
VERILATOR ?= verilator
TOP       ?= ahb_mem_tb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
PASS_MSG  ?= Testbench passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* include/ahb_tb_tasks.svh */
// bench tasks included inside ahb_mem_tb; they drive its bus signals and update its model array
`ifndef AHB_TB_TASKS_SVH
`define AHB_TB_TASKS_SVH

typedef struct packed {
  logic        sel;
  logic [1:0]  trans;
  logic        write;
  logic [2:0]  size;
  logic [31:0] addr;
  logic [31:0] wdata;
} slot_t;

slot_t slots [$];  // address phases waiting to be issued

function automatic slot_t make_slot(logic sel, logic [1:0] trans, logic write,
                                    logic [2:0] size, logic [31:0] addr, logic [31:0] wdata);
  slot_t s;
  s.sel   = sel;
  s.trans = trans;
  s.write = write;
  s.size  = size;
  s.addr  = addr;
  s.wdata = wdata;
  return s;
endfunction

task automatic check_val(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
  if (expected !== actual) begin
    $display("MISMATCH %s expected %h actual %h", name, expected, actual);
    test_errs++;
  end
endtask

// in range, at most a word, and aligned to its own size
function automatic logic xfer_is_legal(logic [31:0] addr, logic [2:0] size);
  if ((addr >> 2) >= 32'(MODEL_WORDS)) return 1'b0;
  if (size > 3'd2) return 1'b0;
  return (addr & ((32'd1 << size) - 32'd1)) == 32'd0;
endfunction

// lanes from the low address bits up to the transfer size take the new bytes
function automatic word_t merge_write(word_t old, word_t wdata, logic [31:0] addr,
                                      logic [2:0] size);
  int    first;
  int    nbytes;
  word_t res;
  first  = int'(addr[1:0]);
  nbytes = 1 << size;
  res    = old;
  for (int b = 0; b < 4; b++) begin
    if (b >= first && b < first + nbytes) begin
      res[8*b +: 8] = wdata[8*b +: 8];
    end
  end
  return res;
endfunction

task automatic drive_addr_phase(input slot_t s);
  hsel_i   = s.sel;
  htrans_i = s.trans;
  haddr_i  = s.addr;
  hwrite_i = s.write;
  hsize_i  = s.size;
endtask

// samples at the falling edge, where outputs are settled
task automatic wait_hready(output int ncyc, output logic resp_first, output logic resp_last);
  logic seen;
  ncyc       = 0;
  seen       = 1'b0;
  resp_first = 1'b0;
  resp_last  = 1'b0;
  while (!seen) begin
    @(negedge clk);
    ncyc++;
    if (ncyc == 1) resp_first = hresp_o;
    resp_last = hresp_o;
    seen      = hready_o;
  end
endtask

task automatic retire_data_phase(input string tname, input slot_t s, input int ncyc,
                                 input logic resp_first, input logic resp_last, input word_t rd);
  int idx;
  idx = int'(s.addr[5:2]);
  if (xfer_is_legal(s.addr, s.size)) begin
    check_val({tname, " hresp"}, 32'(HRESP_OKAY), 32'(resp_last));
    if (ncyc > 3) begin
      $display("%s: data phase took %0d cycles, more than the three allowed", tname, ncyc);
      test_errs++;
    end
    if (s.write) model_mem[idx] = merge_write(model_mem[idx], s.wdata, s.addr, s.size);
    else check_val({tname, " rdata"}, model_mem[idx], rd);
  end else begin
    check_val({tname, " error cycles"}, 32'd2, 32'(ncyc));
    check_val({tname, " error first hresp"}, 32'(HRESP_ERROR), 32'(resp_first));
    check_val({tname, " error last hresp"}, 32'(HRESP_ERROR), 32'(resp_last));
  end
endtask

// address and data phases overlap; each slot is held until hready_o
task automatic run_slots(input string tname);
  slot_t cur;
  slot_t pend;
  logic  have_pend;
  int    ncyc;
  logic  resp_first;
  logic  resp_last;
  word_t rd;
  have_pend = 1'b0;
  pend      = '0;
  slots.push_back(make_slot(1'b0, IDLE, 1'b0, WORD, 32'h0, 32'h0));  // drains the last phase
  while (slots.size() > 0) begin
    cur = slots.pop_front();
    drive_addr_phase(cur);
    hwdata_i = (have_pend && pend.write) ? pend.wdata : $urandom;  // junk under reads
    wait_hready(ncyc, resp_first, resp_last);
    rd = hrdata_o;
    if (have_pend) retire_data_phase(tname, pend, ncyc, resp_first, resp_last, rd);
    have_pend = cur.sel && cur.trans[1];  // NONSEQ or SEQ
    pend      = cur;
    @(posedge clk);
    #DRIVE_DLY;
  end
endtask

`endif

/* bench/ahb_mem_tb.sv */
// self-checking bench for ahb_mem_top with DEPTH 16; the model assumes words start at zero after reset
`timescale 1ns/1ps

module ahb_mem_tb
  import ahb_pkg::*;
();

  localparam int          MODEL_WORDS = 16;
  localparam int          CLK_PERIOD  = 40;
  localparam int          DRIVE_DLY   = 2;
  localparam logic [31:0] SEED        = 32'h3edafadf;

  localparam int N_T1 = MODEL_WORDS;
  localparam int N_T2 = 48;
  localparam int N_T3 = 48;
  localparam int N_T4 = 20 + MODEL_WORDS;
  localparam int N_T5 = 60;
  localparam int N_T6 = 200;
  localparam int N_XFERS    = N_T1 + N_T2 + N_T3 + N_T4 + N_T5 + N_T6 + 6;  // plus drain slots
  localparam int MAX_CYCLES = N_XFERS * 4 + 10 + 100;

  logic        clk;
  logic        rst;
  logic        hsel_i;
  logic [31:0] haddr_i;
  logic        hwrite_i;
  logic [2:0]  hsize_i;
  logic [1:0]  htrans_i;
  logic [31:0] hwdata_i;
  logic [31:0] hrdata_o;
  logic        hready_o;
  logic        hresp_o;

  word_t model_mem [MODEL_WORDS];
  int    test_errs = 0;
  int    n_pass    = 0;
  int    n_fail    = 0;
  int    cycle_cnt = 0;

  `include "ahb_tb_tasks.svh"

  ahb_mem_top #(
    .DEPTH (MODEL_WORDS)
  ) dut0 (
    .clk      (clk),
    .rst      (rst),
    .hsel_i   (hsel_i),
    .haddr_i  (haddr_i),
    .hwrite_i (hwrite_i),
    .hsize_i  (hsize_i),
    .htrans_i (htrans_i),
    .hwdata_i (hwdata_i),
    .hrdata_o (hrdata_o),
    .hready_o (hready_o),
    .hresp_o  (hresp_o)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      $display("Testbench failed");
      $finish;
    end
  end

  // any in-range aligned transfer of the given kind
  function automatic slot_t good_slot(logic write, logic [2:0] size);
    logic [31:0] addr;
    addr = 32'($urandom_range(MODEL_WORDS - 1)) << 2;
    if (size == BYTE) addr[1:0] = 2'($urandom_range(3));
    else if (size == HALF) addr[1] = 1'($urandom_range(1));
    return make_slot(1'b1, $urandom_range(1) ? SEQ : NONSEQ, write, size, addr, $urandom);
  endfunction

  function automatic slot_t bad_slot(int kind);
    logic [31:0] addr;
    logic [2:0]  size;
    addr = 32'($urandom_range(MODEL_WORDS - 1)) << 2;
    size = WORD;
    case (kind)
      0: addr = $urandom | 32'h0000_0040;   // word 16 or above
      1: begin
        size    = HALF;
        addr[0] = 1'b1;
        addr[1] = 1'($urandom_range(1));
      end
      2: addr[1:0] = 2'($urandom_range(3, 1));
      default: size = 3'($urandom_range(7, 3));
    endcase
    return make_slot(1'b1, NONSEQ, 1'($urandom_range(1)), size, addr, $urandom);
  endfunction

  function automatic slot_t word_read(logic [3:0] word);
    return make_slot(1'b1, NONSEQ, 1'b0, WORD, {26'd0, word, 2'b00}, 32'h0);
  endfunction

  task automatic report_test(input string name);
    if (test_errs == 0) begin
      $display("PASS %s", name);
      n_pass++;
    end else begin
      $display("FAIL %s with %0d errors", name, test_errs);
      n_fail++;
    end
    test_errs = 0;
  endtask

  task automatic read_all_words();
    for (int w = 0; w < N_T1; w++) slots.push_back(word_read(4'(w)));
    run_slots("reset_reads_zero");
    report_test("reset_reads_zero");
  endtask

  task automatic write_read_words();
    slot_t       s;
    logic [31:0] addrs [$];
    for (int i = 0; i < N_T2 / 2; i++) begin
      s = good_slot(1'b1, WORD);
      addrs.push_back(s.addr);
      slots.push_back(s);
    end
    foreach (addrs[i]) slots.push_back(word_read(addrs[i][5:2]));
    run_slots("word_write_read");
    report_test("word_write_read");
  endtask

  task automatic merge_partial_writes();
    slot_t s;
    for (int i = 0; i < N_T3 / 2; i++) begin
      s = good_slot(1'b1, 3'($urandom_range(1)));   // byte or halfword
      slots.push_back(s);
      slots.push_back(word_read(s.addr[5:2]));
    end
    run_slots("partial_merge");
    report_test("partial_merge");
  endtask

  task automatic reject_bad_transfers();
    slot_t s;
    for (int i = 0; i < 10; i++) begin
      s = bad_slot(i % 4);
      slots.push_back(s);
      slots.push_back(word_read(s.addr[5:2]));   // the word it aimed at
    end
    for (int w = 0; w < MODEL_WORDS; w++) slots.push_back(word_read(4'(w)));
    run_slots("error_response");
    report_test("error_response");
  endtask

  task automatic pipelined_with_gaps();
    slot_t s;
    for (int i = 0; i < N_T5; i++) begin
      s = good_slot(1'($urandom_range(1)), 3'($urandom_range(2)));
      case ($urandom_range(4))
        0: s.trans = IDLE;
        1: s.trans = BUSY;
        2: s.sel = 1'b0;      // a live transfer aimed at another slave
        default: ;
      endcase
      slots.push_back(s);
    end
    run_slots("pipelined_gaps");
    report_test("pipelined_gaps");
  endtask

  task automatic random_mix();
    for (int i = 0; i < N_T6; i++) begin
      if ($urandom_range(99) < 15) slots.push_back(bad_slot(int'($urandom_range(3))));
      else slots.push_back(good_slot(1'($urandom_range(1)), 3'($urandom_range(2))));
    end
    run_slots("random_mix");
    report_test("random_mix");
  endtask

  initial begin
    void'($urandom(SEED));
    rst      = 1'b0;
    hsel_i   = 1'b0;
    haddr_i  = '0;
    hwrite_i = 1'b0;
    hsize_i  = '0;
    htrans_i = '0;
    hwdata_i = '0;
    for (int i = 0; i < MODEL_WORDS; i++) model_mem[i] = '0;
    repeat (10) @(posedge clk);
    #DRIVE_DLY rst = 1'b1;
    @(posedge clk);
    #DRIVE_DLY;
    read_all_words();
    write_read_words();
    merge_partial_writes();
    reject_bad_transfers();
    pipelined_with_gaps();
    random_mix();
    $display("tests passed: %0d, tests failed: %0d", n_pass, n_fail);
    if (n_fail == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

/* flist.f */
+incdir+include
rtl/ahb_pkg.sv
rtl/mem_req_if.sv
rtl/ahb_slave_ctrl.sv
rtl/word_mem.sv
rtl/ahb_mem_top.sv
bench/ahb_mem_tb.sv

/* rtl/ahb_mem_top.sv */
// AHB-Lite slave with a DEPTH-word memory behind it; one slave only, so hready_o is also the bus ready
`timescale 1ns/1ps

module ahb_mem_top
  import ahb_pkg::*;
#(
  parameter int DEPTH = 16
) (
  input  logic        clk,
  input  logic        rst,
  input  logic        hsel_i,
  input  logic [31:0] haddr_i,
  input  logic        hwrite_i,
  input  logic [2:0]  hsize_i,
  input  logic [1:0]  htrans_i,
  input  logic [31:0] hwdata_i,
  output logic [31:0] hrdata_o,
  output logic        hready_o,
  output logic        hresp_o
);

  mem_req_if #(
    .DEPTH (DEPTH)
  ) mreq ();

  ahb_slave_ctrl #(
    .DEPTH (DEPTH)
  ) u_ctrl (
    .clk      (clk),
    .rst      (rst),
    .hsel_i   (hsel_i),
    .haddr_i  (haddr_i),
    .hwrite_i (hwrite_i),
    .hsize_i  (hsize_t'(hsize_i)),    // wire codes map straight onto the enums
    .htrans_i (htrans_t'(htrans_i)),
    .hwdata_i (hwdata_i),
    .hrdata_o (hrdata_o),
    .hready_o (hready_o),
    .hresp_o  (hresp_o),
    .mem      (mreq.ctrl)
  );

  word_mem #(
    .DEPTH (DEPTH)
  ) u_mem (
    .clk (clk),
    .rst (rst),
    .mem (mreq.mem)
  );

endmodule

/* rtl/ahb_pkg.sv */
// shared AHB-Lite encodings and data types; the data bus is fixed at 32 bits, no other width works
package ahb_pkg;

  // data bus width, not a parameter anywhere in the design
  localparam int DATA_W = 32;

  // transfer type on htrans
  typedef enum logic [1:0] {
    IDLE   = 2'b00,
    BUSY   = 2'b01,
    NONSEQ = 2'b10,
    SEQ    = 2'b11
  } htrans_t;

  // transfer size on hsize, codes above WORD are legal but get an error
  typedef enum logic [2:0] {
    BYTE = 3'b000,
    HALF = 3'b001,
    WORD = 3'b010
  } hsize_t;

  // response on hresp
  localparam logic HRESP_OKAY  = 1'b0;
  localparam logic HRESP_ERROR = 1'b1;

  // one bus word
  typedef logic [DATA_W-1:0] word_t;

  // one enable per byte lane of a word
  typedef logic [DATA_W/8-1:0] strb_t;

endpackage

/* rtl/ahb_slave_ctrl.sv */
// lone AHB-Lite slave driving the bus ready; SEQ taken as NONSEQ; no burst, hprot or lock
`timescale 1ns/1ps

module ahb_slave_ctrl
  import ahb_pkg::*;
#(
  parameter int DEPTH = 16
) (
  input  logic        clk,
  input  logic        rst,
  input  logic        hsel_i,
  input  logic [31:0] haddr_i,
  input  logic        hwrite_i,
  input  hsize_t      hsize_i,
  input  htrans_t     htrans_i,
  input  word_t       hwdata_i,
  output word_t       hrdata_o,
  output logic        hready_o,
  output logic        hresp_o,
  mem_req_if.ctrl     mem
);

  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  typedef enum logic [1:0] {
    ST_IDLE = 2'b00,  // no data phase open
    ST_DATA = 2'b01,  // good transfer waiting on the memory
    ST_ERR1 = 2'b10,  // first error cycle, hready low
    ST_ERR2 = 2'b11   // second error cycle, hready high
  } ctrl_state_t;

  ctrl_state_t   state_q;
  ctrl_state_t   state_d;

  logic          accept;         // address phase taken this cycle
  logic          word_in_range;
  logic          size_ok;
  logic          aligned;
  logic          xfer_ok;

  logic [AW-1:0] addr_q;         // captured address phase fields
  logic [1:0]    lane_q;
  hsize_t        size_q;
  logic          write_q;
  strb_t         strb_w;

  // address phase

  assign accept = hsel_i && (htrans_i == NONSEQ || htrans_i == SEQ) && hready_o;

  assign word_in_range = (haddr_i[31:2] < 30'(DEPTH));
  assign size_ok       = (hsize_i <= WORD);

  always_comb begin
    case (hsize_i)
      BYTE:    aligned = 1'b1;
      HALF:    aligned = ~haddr_i[0];
      WORD:    aligned = (haddr_i[1:0] == 2'b00);
      default: aligned = 1'b1;                  // wider sizes are left to size_ok
    endcase
  end

  assign xfer_ok = word_in_range && size_ok && aligned;

  always_ff @(posedge clk) begin
    if (accept) begin
      addr_q  <= haddr_i[AW+1:2];
      lane_q  <= haddr_i[1:0];
      size_q  <= hsize_i;
      write_q <= hwrite_i;
    end
  end

  // phase sequencing

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_DATA: begin
        if (mem.ready) begin
          state_d = ST_IDLE;
        end
      end
      ST_ERR1: state_d = ST_ERR2;
      ST_ERR2: state_d = ST_IDLE;
      default: state_d = ST_IDLE;
    endcase
    // a new address phase can overlap the last data cycle
    if (accept) begin
      state_d = xfer_ok ? ST_DATA : ST_ERR1;
    end
  end

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    case (state_q)
      ST_DATA: hready_o = mem.ready;   // wait states come from the memory
      ST_ERR1: hready_o = 1'b0;
      default: hready_o = 1'b1;
    endcase
  end

  assign hresp_o = (state_q == ST_ERR1 || state_q == ST_ERR2) ? HRESP_ERROR : HRESP_OKAY;

  // byte lanes from the captured size and low address bits

  always_comb begin
    case (size_q)
      BYTE:    strb_w = 4'b0001 << lane_q;
      HALF:    strb_w = 4'b0011 << lane_q;   // lane_q[0] is zero here
      default: strb_w = 4'b1111;
    endcase
  end

  // memory request and data passthrough

  assign mem.req   = (state_q == ST_DATA);
  assign mem.rnw   = ~write_q;
  assign mem.waddr = addr_q;
  assign mem.strb  = strb_w;
  assign mem.wdata = hwdata_i;        // bus write data is valid in the data phase
  assign hrdata_o  = mem.rdata;       // zero outside a read

  // an ERROR with ready must follow the ERROR cycle with ready low
  a_err_two_cycle : assert property (
    @(posedge clk) disable iff (!rst)
    (hresp_o && hready_o) |-> $past(hresp_o && !hready_o)
  );

  // a rejected transfer makes no memory request in its two error cycles
  a_err_no_req : assert property (
    @(posedge clk) disable iff (!rst)
    (accept && !xfer_ok) |=> (!mem.req ##1 !mem.req)
  );

endmodule

/* rtl/mem_req_if.sv */
// level request port between bus controller and word memory; fields must hold while req waits
`timescale 1ns/1ps

interface mem_req_if
  import ahb_pkg::*;
#(
  parameter int DEPTH = 16
) ();

  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;  // word address width

  logic          req;    // access wanted, held until ready
  logic          rnw;    // 1 read, 0 write
  logic [AW-1:0] waddr;  // word address
  word_t         wdata;
  strb_t         strb;   // byte lanes to write
  logic          ready;  // memory side, toggles on its own
  word_t         rdata;  // zero unless a read is requested

  modport ctrl (
    output req, rnw, waddr, wdata, strb,
    input  ready, rdata
  );

  modport mem (
    input  req, rnw, waddr, wdata, strb,
    output ready, rdata
  );

endinterface

/* rtl/word_mem.sv */
// word memory with byte writes and counter-based wait states; ready is never low for more than two cycles
`timescale 1ns/1ps

module word_mem
  import ahb_pkg::*;
#(
  parameter int DEPTH = 16
) (
  input  logic   clk,
  input  logic   rst,
  mem_req_if.mem mem
);

  localparam int LANES = DATA_W / 8;

  word_t      mem_q [DEPTH];
  logic [3:0] cnt_q;          // free-running, sets the ready pattern
  logic       odd_not3;
  logic       do_write;

  // ready pattern

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_q + 4'd1;
    end
  end

  assign odd_not3 = (cnt_q % 4'd2 != 4'd0) && (cnt_q % 4'd3 != 4'd0);

  // the extra term on counts 10 and 11 breaks the 8,9,10 gap
  assign mem.ready = odd_not3 || cnt_q[2] || (cnt_q[3] && cnt_q[1]);

  // storage

  assign do_write = mem.req && mem.ready && !mem.rnw;

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      for (int i = 0; i < DEPTH; i++) begin
        mem_q[i] <= '0;
      end
    end else if (do_write) begin
      for (int b = 0; b < LANES; b++) begin
        if (mem.strb[b]) begin
          mem_q[mem.waddr][8*b +: 8] <= mem.wdata[8*b +: 8];  // only enabled lanes
        end
      end
    end
  end

  assign mem.rdata = (mem.req && mem.rnw) ? mem_q[mem.waddr] : '0;

  // the controller range check keeps requests inside the array
  a_addr_in_range : assert property (
    @(posedge clk) disable iff (!rst)
    mem.req |-> (int'(mem.waddr) < DEPTH)
  );

endmodule
